//--- jac_settings.svh
/* jacobian engine settings
   dimensions, data widths and frame slot positions */
`ifndef JAC_SETTINGS_SVH
`define JAC_SETTINGS_SVH

// matrix datapath
`define JAC_DIM        3   // rows and columns of every matrix
`define JAC_ELEM_W     18  // operand element width
`define JAC_ACC_W      44  // accumulator width, leaves headroom over 2*ELEM_W

// element-wise lanes
`define JAC_LANES      9
`define JAC_LANE_W     9

// frame timing, counted in enabled cycles
`define JAC_FRAME      12  // counts per frame
`define JAC_CLEAR_SLOT 1   // clear issued one cycle after this count
`define JAC_ACC_SLOTS  10  // accumulate while count is below this

`endif

//--- jac_pkg.sv
/* jacobian engine types
   element, product, accumulator, lane and frame count types */
`include "jac_settings.svh"

package jac_pkg;

	// matrix datapath
	typedef logic signed [`JAC_ELEM_W-1:0]   elem_t;      // operand element
	typedef logic signed [2*`JAC_ELEM_W-1:0] prod_t;      // full element product
	typedef logic signed [`JAC_ACC_W-1:0]    acc_t;       // accumulator entry

	// element-wise lanes
	typedef logic signed [`JAC_LANE_W-1:0]   lane_t;      // lane value
	typedef logic signed [2*`JAC_LANE_W-1:0] lane_prod_t; // full lane product

	// frame counter, wide enough for JAC_FRAME-1
	typedef logic [3:0] count_t;

endpackage

//--- mult_cell.sv
/* registered signed multiplier
   full product of two operands, sign-extended into the result type */
`timescale 1ns/1ps

module mult_cell #(
	parameter type operand_t = logic signed [7:0],
	parameter type result_t  = logic signed [15:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     en,
	input  operand_t a,
	input  operand_t b,
	output result_t  p
);

	result_t a_ext; // operands widened to the product width
	result_t b_ext;

	// signed cast keeps the sign on widening
	assign a_ext = result_t'(a);
	assign b_ext = result_t'(b);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			p <= '0;
		end else if (en) begin
			p <= a_ext * b_ext; // cannot overflow, result is twice operand width
		end
	end

	//**************************************************************************
	// checks
	//**************************************************************************

	// an X on an operand would otherwise surface only downstream in the sums
	assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(p))
		else $error("mult_cell: product is unknown");

endmodule

//--- mat_mult.sv
/* matrix multiply-accumulate unit
   adds the product of two DIM x DIM matrices into the result each enabled cycle */
`timescale 1ns/1ps
`include "jac_settings.svh"

module mat_mult
	import jac_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  en,
	input  logic  acc_mode,                            // add products into result
	input  logic  acc_clear,                           // load, overrides acc_mode
	input  elem_t mat_a      [`JAC_DIM][`JAC_DIM],
	input  elem_t mat_b      [`JAC_DIM][`JAC_DIM],
	output acc_t  mat_result [`JAC_DIM][`JAC_DIM]
);

	prod_t prod [`JAC_DIM][`JAC_DIM][`JAC_DIM]; // [row][col][inner], stage 1
	acc_t  dot  [`JAC_DIM][`JAC_DIM];           // row-column sums of stage 1

	//**************************************************************************
	// stage 1: one multiplier per (row, column, inner) triple
	//**************************************************************************

	genvar i, j, k;
	generate
		for (i = 0; i < `JAC_DIM; i++) begin : g_row
			for (j = 0; j < `JAC_DIM; j++) begin : g_col
				for (k = 0; k < `JAC_DIM; k++) begin : g_inner
					mult_cell #(
						.operand_t (elem_t),
						.result_t  (prod_t)
					) mult_inst (
						.clk    (clk),
						.arst_n (arst_n),
						.en     (en),
						.a      (mat_a[i][k]),
						.b      (mat_b[k][j]),
						.p      (prod[i][j][k])
					);
				end
			end
		end
	endgenerate

	// inner sums, products sign-extended to accumulator width
	always_comb begin
		for (int r = 0; r < `JAC_DIM; r++) begin
			for (int c = 0; c < `JAC_DIM; c++) begin
				dot[r][c] = '0;
				for (int n = 0; n < `JAC_DIM; n++) begin
					dot[r][c] = dot[r][c] + acc_t'(prod[r][c][n]);
				end
			end
		end
	end

	//**************************************************************************
	// stage 2: accumulator, clear has priority over mode
	//**************************************************************************

	generate
		for (i = 0; i < `JAC_DIM; i++) begin : g_acc_row
			for (j = 0; j < `JAC_DIM; j++) begin : g_acc_col
				always_ff @(posedge clk or negedge arst_n) begin
					if (!arst_n) begin
						mat_result[i][j] <= '0;
					end else if (en) begin
						if (acc_clear) begin
							mat_result[i][j] <= dot[i][j];    // restart from one product
						end else if (acc_mode) begin
							mat_result[i][j] <= mat_result[i][j] + dot[i][j];
						end
						// otherwise hold for readout
					end
				end
			end
		end
	endgenerate

	//**************************************************************************
	// checks
	//**************************************************************************

	// the frame slots place the clear inside the accumulate window
	assert property (@(posedge clk) disable iff (!arst_n) acc_clear |-> acc_mode)
		else $error("mat_mult: acc_clear outside accumulate window");

endmodule

//--- array_mult.sv
/* element-wise array multiplier
   nine signed lane products, each saturated back to the lane width */
`timescale 1ns/1ps
`include "jac_settings.svh"

module array_mult
	import jac_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  en,
	input  lane_t lane_a      [`JAC_LANES],
	input  lane_t lane_b      [`JAC_LANES],
	output lane_t lane_result [`JAC_LANES]
);

	// lane range limits
	localparam lane_t lane_max = {1'b0, {(`JAC_LANE_W-1){1'b1}}};
	localparam lane_t lane_min = {1'b1, {(`JAC_LANE_W-1){1'b0}}};

	lane_prod_t prod [`JAC_LANES]; // registered full products
	lane_t      sat  [`JAC_LANES]; // clamped products

	genvar l;
	generate
		for (l = 0; l < `JAC_LANES; l++) begin : g_lane
			mult_cell #(
				.operand_t (lane_t),
				.result_t  (lane_prod_t)
			) mult_inst (
				.clk    (clk),
				.arst_n (arst_n),
				.en     (en),
				.a      (lane_a[l]),
				.b      (lane_b[l]),
				.p      (prod[l])
			);

			// clamp to the lane range
			always_comb begin
				if (prod[l] > lane_prod_t'(lane_max)) begin
					sat[l] = lane_max;
				end else if (prod[l] < lane_prod_t'(lane_min)) begin
					sat[l] = lane_min;
				end else begin
					sat[l] = lane_t'(prod[l]); // in range so only sign bits drop
				end
			end

			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					lane_result[l] <= '0;
				end else if (en) begin
					lane_result[l] <= sat[l];
				end
			end

			// result keeps the sign of its product and lies between zero and that product
			assert property (@(posedge clk) disable iff (!arst_n)
				en |=> ((lane_result[l] < 0) == ($past(prod[l]) < 0))
					&& (($past(prod[l]) < 0)
						? (lane_prod_t'(lane_result[l]) >= $past(prod[l]))
						: (lane_prod_t'(lane_result[l]) <= $past(prod[l]))))
				else $error("array_mult: lane %0d result out of range", l);
		end
	endgenerate

endmodule

//--- jac_sequencer.sv
/* frame sequencer
   wrapping frame counter, accumulate mode level and delayed clear pulse */
`timescale 1ns/1ps
`include "jac_settings.svh"

module jac_sequencer
	import jac_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   en,
	output count_t frame_count,
	output logic   acc_mode,
	output logic   acc_clear
);

	localparam count_t last_count = count_t'(`JAC_FRAME - 1);
	localparam count_t clear_slot = count_t'(`JAC_CLEAR_SLOT);
	localparam count_t acc_slots  = count_t'(`JAC_ACC_SLOTS);

	//**************************************************************************
	// frame counter
	//**************************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_count <= '0;
		end else if (en) begin
			if (frame_count == last_count) begin
				frame_count <= '0; // wrap to next frame
			end else begin
				frame_count <= frame_count + 1'b1;
			end
		end
	end

	//**************************************************************************
	// matrix unit controls
	//**************************************************************************

	assign acc_mode = (frame_count < acc_slots); // accumulate window at frame start

	// one enabled cycle late so it lines up with the product stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc_clear <= 1'b0;
		end else if (en) begin
			acc_clear <= (frame_count == clear_slot);
		end
	end

	// checks
	assert property (@(posedge clk) disable iff (!arst_n)
		frame_count < count_t'(`JAC_FRAME))
		else $error("jac_sequencer: frame_count %0d past frame end", frame_count);

endmodule

//--- jacobian_core.sv
/* jacobian update engine top level
   frame sequencer driving the matrix MAC, alongside the lane multiplier */
`timescale 1ns/1ps
`include "jac_settings.svh"

module jacobian_core
	import jac_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   en,                                  // global stall, low holds all state

	// matrix operands and accumulated product
	input  elem_t  mat_a       [`JAC_DIM][`JAC_DIM],
	input  elem_t  mat_b       [`JAC_DIM][`JAC_DIM],
	output acc_t   mat_result  [`JAC_DIM][`JAC_DIM],

	// element-wise lanes
	input  lane_t  lane_a      [`JAC_LANES],
	input  lane_t  lane_b      [`JAC_LANES],
	output lane_t  lane_result [`JAC_LANES],

	output count_t frame_count
);

	logic acc_mode;  // sequencer to matrix unit
	logic acc_clear;

	//**************************************************************************
	// frame control
	//**************************************************************************

	jac_sequencer jac_sequencer_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.en          (en),
		.frame_count (frame_count),
		.acc_mode    (acc_mode),
		.acc_clear   (acc_clear)
	);

	//**************************************************************************
	// arithmetic units
	//**************************************************************************

	mat_mult mat_mult_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.en         (en),
		.acc_mode   (acc_mode),
		.acc_clear  (acc_clear),
		.mat_a      (mat_a),
		.mat_b      (mat_b),
		.mat_result (mat_result)
	);

	// lanes run free of the frame, only the stall applies
	array_mult array_mult_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.en          (en),
		.lane_a      (lane_a),
		.lane_b      (lane_b),
		.lane_result (lane_result)
	);

endmodule

//--- jacobian_tb.sv
/* jacobian engine testbench
   table-driven stimulus checked against a cycle model of the frame, MAC and lane rules */
`timescale 1ns/1ps
`include "jac_settings.svh"

module jacobian_tb
	import jac_pkg::*;
();

	localparam int clk_period_ns = 4;
	localparam int reset_cycles  = 16;

	// operand sources for a table row
	localparam logic [1:0] src_rand  = 2'd0; // full-width LFSR values
	localparam logic [1:0] src_small = 2'd1; // narrow LFSR values, lane products in range
	localparam logic [1:0] src_pos   = 2'd2; // extremes, lanes saturate high
	localparam logic [1:0] src_neg   = 2'd3; // extremes, lanes saturate low

	localparam int lane_max = (1 << (`JAC_LANE_W - 1)) - 1;
	localparam int lane_min = -(1 << (`JAC_LANE_W - 1));
	localparam int elem_max = (1 << (`JAC_ELEM_W - 1)) - 1;
	localparam int elem_min = -(1 << (`JAC_ELEM_W - 1));

	typedef struct packed {
		logic [7:0] len; // cycles in this row
		logic       en;
		logic [1:0] src;
	} row_t;

	localparam int num_rows = 10;
	localparam row_t stim_table [num_rows] = '{
		'{8'd30, 1'b1, src_rand},
		'{8'd4,  1'b1, src_pos},
		'{8'd4,  1'b1, src_neg},
		'{8'd6,  1'b0, src_rand},  // stall while inputs keep moving
		'{8'd20, 1'b1, src_small},
		'{8'd3,  1'b1, src_pos},
		'{8'd5,  1'b0, src_neg},
		'{8'd30, 1'b1, src_rand},
		'{8'd2,  1'b0, src_rand},
		'{8'd10, 1'b1, src_neg}
	};

	logic   clk = 1'b0;
	logic   arst_n;
	logic   en;
	elem_t  mat_a       [`JAC_DIM][`JAC_DIM];
	elem_t  mat_b       [`JAC_DIM][`JAC_DIM];
	acc_t   mat_result  [`JAC_DIM][`JAC_DIM];
	lane_t  lane_a      [`JAC_LANES];
	lane_t  lane_b      [`JAC_LANES];
	lane_t  lane_result [`JAC_LANES];
	count_t frame_count;

	logic [31:0] lfsr_state;

	// reference model state
	int     m_count;
	logic   m_clear;
	longint m_dot   [`JAC_DIM][`JAC_DIM]; // product stage, already summed
	longint m_acc   [`JAC_DIM][`JAC_DIM];
	int     m_lprod [`JAC_LANES];
	int     m_lres  [`JAC_LANES];

	jacobian_core jacobian_core_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.en          (en),
		.mat_a       (mat_a),
		.mat_b       (mat_b),
		.mat_result  (mat_result),
		.lane_a      (lane_a),
		.lane_b      (lane_b),
		.lane_result (lane_result),
		.frame_count (frame_count)
	);

	always #(clk_period_ns / 2) clk = ~clk;

	//**************************************************************************
	// random numbers
	//**************************************************************************

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};    // one step per bit
		end
		return v;
	endfunction

	function automatic int table_cycles();
		int total;
		total = 0;
		for (int r = 0; r < num_rows; r++) begin
			total += int'(stim_table[r].len);
		end
		return total;
	endfunction

	function automatic int clamp_lane(input int p);
		if (p > lane_max) begin
			return lane_max;
		end else if (p < lane_min) begin
			return lane_min;
		end
		return p;
	endfunction

	//**************************************************************************
	// stimulus and model
	//**************************************************************************

	task automatic drive_inputs(input logic [1:0] src);
		logic [31:0] v;
		logic        alt;
		for (int r = 0; r < `JAC_DIM; r++) begin
			for (int c = 0; c < `JAC_DIM; c++) begin
				alt = ((r + c) % 2) == 1;
				case (src)
					src_rand: begin
						mat_a[r][c] = elem_t'(take_bits(`JAC_ELEM_W));
						mat_b[r][c] = elem_t'(take_bits(`JAC_ELEM_W));
					end
					src_small: begin
						v = take_bits(6);
						mat_a[r][c] = elem_t'($signed(v[5:0]));
						v = take_bits(6);
						mat_b[r][c] = elem_t'($signed(v[5:0]));
					end
					src_pos: begin
						mat_a[r][c] = elem_t'(alt ? elem_min : elem_max);
						mat_b[r][c] = elem_t'(alt ? elem_min : elem_max);
					end
					default: begin
						mat_a[r][c] = elem_t'(alt ? elem_min : elem_max);
						mat_b[r][c] = elem_t'(alt ? elem_max : elem_min);
					end
				endcase
			end
		end
		for (int l = 0; l < `JAC_LANES; l++) begin
			alt = (l % 2) == 1;
			case (src)
				src_rand: begin
					lane_a[l] = lane_t'(take_bits(`JAC_LANE_W));
					lane_b[l] = lane_t'(take_bits(`JAC_LANE_W));
				end
				src_small: begin
					v = take_bits(4);
					lane_a[l] = lane_t'($signed(v[3:0]));
					v = take_bits(4);
					lane_b[l] = lane_t'($signed(v[3:0]));
				end
				src_pos: begin
					lane_a[l] = lane_t'(alt ? lane_min : lane_max); // same signs
					lane_b[l] = lane_t'(alt ? lane_min : lane_max);
				end
				default: begin
					lane_a[l] = lane_t'(alt ? lane_min : lane_max); // opposite signs
					lane_b[l] = lane_t'(alt ? lane_max : lane_min);
				end
			endcase
		end
	endtask

	// one enabled edge, every update reads the state from before the edge
	task automatic step_model();
		if (en) begin
			for (int r = 0; r < `JAC_DIM; r++) begin
				for (int c = 0; c < `JAC_DIM; c++) begin
					if (m_clear) begin
						m_acc[r][c] = m_dot[r][c];
					end else if (m_count < `JAC_ACC_SLOTS) begin
						m_acc[r][c] = m_acc[r][c] + m_dot[r][c];
					end
				end
			end
			m_clear = (m_count == `JAC_CLEAR_SLOT);
			m_count = (m_count == `JAC_FRAME - 1) ? 0 : m_count + 1;
			for (int r = 0; r < `JAC_DIM; r++) begin
				for (int c = 0; c < `JAC_DIM; c++) begin
					m_dot[r][c] = 0;
					for (int n = 0; n < `JAC_DIM; n++) begin
						m_dot[r][c] += longint'(mat_a[r][n]) * longint'(mat_b[n][c]);
					end
				end
			end
			for (int l = 0; l < `JAC_LANES; l++) begin
				m_lres[l]  = clamp_lane(m_lprod[l]);
				m_lprod[l] = int'(lane_a[l]) * int'(lane_b[l]);
			end
		end
	endtask

	//**************************************************************************
	// checks
	//**************************************************************************

	task automatic stop_on_error();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_outputs();
		assert (frame_count == count_t'(m_count)) else begin
			$display("mismatch frame_count: got %h expected %h", frame_count, count_t'(m_count));
			stop_on_error();
		end
		for (int r = 0; r < `JAC_DIM; r++) begin
			for (int c = 0; c < `JAC_DIM; c++) begin
				assert (mat_result[r][c] == acc_t'(m_acc[r][c])) else begin
					$display("mismatch mat_result[%0d][%0d]: got %h expected %h",
						r, c, mat_result[r][c], acc_t'(m_acc[r][c]));
					stop_on_error();
				end
			end
		end
		for (int l = 0; l < `JAC_LANES; l++) begin
			assert (lane_result[l] == lane_t'(m_lres[l])) else begin
				$display("mismatch lane_result[%0d]: got %h expected %h",
					l, lane_result[l], lane_t'(m_lres[l]));
				stop_on_error();
			end
		end
	endtask

	initial begin : watchdog
		longint limit_ns;
		limit_ns = longint'(table_cycles() + reset_cycles) * clk_period_ns * 2;
		#(limit_ns);
		$display("watchdog timeout, run did not finish within %0d ns", limit_ns);
		stop_on_error();
	end

	initial begin : main
		lfsr_state = 32'h5c85;
		arst_n     = 1'b0;
		en         = 1'b0;
		drive_inputs(src_small);
		for (int l = 0; l < `JAC_LANES; l++) begin
			m_lprod[l] = 0;
			m_lres[l]  = 0;
		end
		for (int r = 0; r < `JAC_DIM; r++) begin
			for (int c = 0; c < `JAC_DIM; c++) begin
				m_dot[r][c] = 0;
				m_acc[r][c] = 0;
			end
		end
		m_count = 0;
		m_clear = 1'b0;

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		check_outputs(); // all zero while held in reset
		arst_n = 1'b1;

		for (int r = 0; r < num_rows; r++) begin
			for (int c = 0; c < int'(stim_table[r].len); c++) begin
				en = stim_table[r].en;
				drive_inputs(stim_table[r].src);
				@(posedge clk);
				step_model();
				@(negedge clk);
				check_outputs();
			end
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- all.f
+incdir+.
jac_pkg.sv
mult_cell.sv
mat_mult.sv
array_mult.sv
jac_sequencer.sv
jacobian_core.sv
jacobian_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the jacobian engine testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module jacobian_tb -o jacobian_tb_sim \
	&& ./obj_dir/jacobian_tb_sim 2>&1 | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
